// File: Makefile
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := echo_core_tb
RTL_TOP   := echo_core
FILELIST  := filelist.f
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -qF '** FAIL **' $(LOG); then exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

// File: filelist.f
+incdir+logic
logic/echo_pkg.sv
logic/echo_ifs.sv
logic/ip_rx_parser.sv
logic/udp_echo.sv
logic/icmp_echo.sv
logic/reply_arbiter.sv
logic/ip_tx_framer.sv
logic/echo_core.sv
sim/echo_core_tb.sv

// File: logic/echo_core.sv
`timescale 1ns/100ps

module echo_core (
    input  logic       sys_clk,
    input  logic       rst,
    input  logic [7:0] rx_data,
    input  logic       rx_valid,
    input  logic       rx_last,
    input  logic       rx_err,
    output logic [7:0] tx_data,
    output logic       tx_valid,
    input  logic       tx_ready,
    output logic       tx_last,
    output logic       rx_activity,
    output logic       rx_bad_frame
);

    rx_pay_if pay ();
    reply_if  udp_reply ();
    reply_if  icmp_reply ();
    reply_if  tx_reply ();

    ip_rx_parser u_ip_rx_parser (
        .sys_clk      (sys_clk),
        .rst          (rst),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .rx_last      (rx_last),
        .rx_err       (rx_err),
        .pay          (pay.parser),
        .rx_activity  (rx_activity),
        .rx_bad_frame (rx_bad_frame)
    );

    udp_echo u_udp_echo (
        .sys_clk (sys_clk),
        .rst     (rst),
        .pay     (pay.responder),
        .reply   (udp_reply.source)
    );

    icmp_echo u_icmp_echo (
        .sys_clk (sys_clk),
        .rst     (rst),
        .pay     (pay.responder),
        .reply   (icmp_reply.source)
    );

    reply_arbiter u_reply_arbiter (
        .sys_clk    (sys_clk),
        .rst        (rst),
        .udp_reply  (udp_reply.sink),
        .icmp_reply (icmp_reply.sink),
        .tx_reply   (tx_reply.source)
    );

    ip_tx_framer u_ip_tx_framer (
        .sys_clk  (sys_clk),
        .rst      (rst),
        .tx_reply (tx_reply.sink),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .tx_last  (tx_last)
    );

endmodule

// File: logic/echo_ifs.sv
`timescale 1ns/100ps

interface rx_pay_if;
    logic [7:0]  data;
    logic        valid;
    logic        last;
    logic        err;
    logic        udp_sel;
    logic        icmp_sel;
    logic [31:0] src_ip;
    logic [15:0] src_port;
    logic [15:0] icmp_csum;

    modport parser (output data, valid, last, err, udp_sel, icmp_sel,
                    src_ip, src_port, icmp_csum);
    modport responder (input data, valid, last, err, udp_sel, icmp_sel,
                       src_ip, src_port, icmp_csum);
endinterface

interface reply_if;
    logic                  req;
    echo_pkg::reply_meta_t meta;
    logic [7:0]            data;
    logic                  valid;
    logic                  last;
    logic                  ready;

    modport source (output req, meta, data, valid, last, input ready);
    modport sink (input req, meta, data, valid, last, output ready);
endinterface

// File: logic/echo_pkg.sv
package echo_pkg;

    typedef enum logic [7:0] {
        PROTO_ICMP = 8'd1,
        PROTO_UDP  = 8'd17
    } ip_proto_t;

    typedef enum logic [7:0] {
        ICMP_ECHO_REPLY   = 8'd0,
        ICMP_ECHO_REQUEST = 8'd8
    } icmp_type_t;

    typedef enum logic [1:0] {RX_IP_HDR, RX_L4_HDR, RX_PAYLOAD, RX_SKIP} rx_state_t;

    typedef enum logic [1:0] {TX_IDLE, TX_IP_HDR, TX_L4_HDR, TX_PAYLOAD} tx_state_t;

    // UDP: {src port, dst port}; ICMP: {type, code, checksum}
    typedef struct packed {
        ip_proto_t   proto;
        logic [31:0] dst_ip;
        logic [31:0] l4_word_a;
        logic [15:0] udp_len;
        logic [6:0]  pay_len;
    } reply_meta_t;

endpackage

// File: logic/echo_settings.svh
`ifndef ECHO_SETTINGS_SVH
`define ECHO_SETTINGS_SVH

// 192.168.2.128
`define LOCAL_IP         32'hC0A80280
`define UDP_ECHO_PORT    16'd1234
`define REPLY_TTL        8'd64

// Bytes per responder buffer
`define ECHO_MAX_PAYLOAD 64

`endif

// File: logic/icmp_echo.sv
`timescale 1ns/100ps
`include "echo_settings.svh"

module icmp_echo (
    input logic         sys_clk,
    input logic         rst,
    rx_pay_if.responder pay,
    reply_if.source     reply
);

    localparam int LEN_W = $clog2(`ECHO_MAX_PAYLOAD) + 1;

    logic [7:0]       pay_mem [`ECHO_MAX_PAYLOAD];
    logic [LEN_W-1:0] wr_cnt;
    logic [LEN_W-1:0] rd_cnt;
    logic             drop;
    logic             sel_byte;
    logic             wr_ok;
    logic [16:0]      csum_sum;
    logic [15:0]      reply_csum;

    assign sel_byte = pay.valid && pay.icmp_sel;
    assign wr_ok    = sel_byte && !reply.req && !drop &&
                      (wr_cnt != LEN_W'(`ECHO_MAX_PAYLOAD));

    // Type 8 to 0 raises the checksum by 0x0800, end-around carry
    assign csum_sum   = {1'b0, pay.icmp_csum} + 17'h00800;
    assign reply_csum = csum_sum[15:0] + 16'(csum_sum[16]);

    always_ff @(posedge sys_clk) begin
        if (wr_ok) begin
            pay_mem[wr_cnt[LEN_W-2:0]] <= pay.data;
        end
        if (wr_ok && pay.last) begin
            reply.meta <= '{proto:     echo_pkg::PROTO_ICMP,
                            dst_ip:    pay.src_ip,
                            l4_word_a: {echo_pkg::ICMP_ECHO_REPLY, 8'h00, reply_csum},
                            udp_len:   16'h0000,
                            pay_len:   wr_cnt + 1'b1};
        end
    end

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            wr_cnt    <= '0;
            rd_cnt    <= '0;
            drop      <= 1'b0;
            reply.req <= 1'b0;
        end else begin
            if (sel_byte) begin
                wr_cnt <= pay.last ? '0 : wr_cnt + LEN_W'(wr_ok);
                drop   <= !pay.last && !wr_ok;
            end
            if (wr_ok && pay.last && !pay.err) begin
                reply.req <= 1'b1;
            end
            if (reply.valid && reply.ready) begin
                rd_cnt <= reply.last ? '0 : rd_cnt + 1'b1;
                if (reply.last) begin
                    reply.req <= 1'b0;
                end
            end
        end
    end

    assign reply.valid = reply.req;
    assign reply.data  = pay_mem[rd_cnt[LEN_W-2:0]];
    assign reply.last  = (rd_cnt + 1'b1 == LEN_W'(reply.meta.pay_len));

endmodule

// File: logic/ip_rx_parser.sv
`timescale 1ns/100ps
`include "echo_settings.svh"

module ip_rx_parser (
    input  logic       sys_clk,
    input  logic       rst,
    input  logic [7:0] rx_data,
    input  logic       rx_valid,
    input  logic       rx_last,
    input  logic       rx_err,
    rx_pay_if.parser   pay,
    output logic       rx_activity,
    output logic       rx_bad_frame
);

    echo_pkg::rx_state_t state;
    echo_pkg::ip_proto_t proto;
    logic [4:0]          cnt;
    logic [23:0]         sr;
    logic                err_seen;
    logic                in_pay;

    assign in_pay       = (state == echo_pkg::RX_PAYLOAD);
    assign pay.data     = rx_data;
    assign pay.valid    = rx_valid && in_pay;
    assign pay.last     = rx_last;
    assign pay.err      = rx_err || err_seen;
    assign pay.udp_sel  = in_pay && (proto == echo_pkg::PROTO_UDP);
    assign pay.icmp_sel = in_pay && (proto == echo_pkg::PROTO_ICMP);

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            state    <= echo_pkg::RX_IP_HDR;
            cnt      <= '0;
            err_seen <= 1'b0;
        end else if (rx_valid) begin
            cnt      <= cnt + 5'd1;
            err_seen <= (err_seen || rx_err) && !rx_last;
            if (rx_last) begin
                state <= echo_pkg::RX_IP_HDR;
                cnt   <= '0;
            end else begin
                case (state)
                    echo_pkg::RX_IP_HDR: begin
                        if ((cnt == 5'd0 && rx_data != 8'h45) ||
                            (cnt == 5'd9 && rx_data != echo_pkg::PROTO_UDP &&
                             rx_data != echo_pkg::PROTO_ICMP) ||
                            (cnt == 5'd19 && {sr[23:0], rx_data} != `LOCAL_IP)) begin
                            state <= echo_pkg::RX_SKIP;
                        end else if (cnt == 5'd19) begin
                            state <= echo_pkg::RX_L4_HDR;
                            cnt   <= '0;
                        end
                    end
                    echo_pkg::RX_L4_HDR: begin
                        if (proto == echo_pkg::PROTO_UDP) begin
                            // Destination port sits in bytes 2 and 3
                            if (cnt == 5'd3 && {sr[7:0], rx_data} != `UDP_ECHO_PORT) begin
                                state <= echo_pkg::RX_SKIP;
                            end else if (cnt == 5'd7) begin
                                state <= echo_pkg::RX_PAYLOAD;
                            end
                        end else begin
                            if (cnt == 5'd0 && rx_data != echo_pkg::ICMP_ECHO_REQUEST) begin
                                state <= echo_pkg::RX_SKIP;
                            end else if (cnt == 5'd3) begin
                                state <= echo_pkg::RX_PAYLOAD;
                            end
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // Header field capture
    always_ff @(posedge sys_clk) begin
        if (rx_valid) begin
            sr <= {sr[15:0], rx_data};
            if (state == echo_pkg::RX_IP_HDR && cnt == 5'd9) begin
                proto <= echo_pkg::ip_proto_t'(rx_data);
            end
            if (state == echo_pkg::RX_IP_HDR && cnt == 5'd15) begin
                pay.src_ip <= {sr[23:0], rx_data};
            end
            if (state == echo_pkg::RX_L4_HDR && cnt == 5'd1) begin
                pay.src_port <= {sr[7:0], rx_data};
            end
            if (state == echo_pkg::RX_L4_HDR && cnt == 5'd3) begin
                pay.icmp_csum <= {sr[7:0], rx_data};
            end
        end
    end

    // Sticky status flags modelled on the board LEDs
    always_ff @(posedge sys_clk) begin
        if (rst) begin
            rx_activity  <= 1'b0;
            rx_bad_frame <= 1'b0;
        end else if (rx_valid) begin
            rx_activity <= 1'b1;
            if (rx_err) begin
                rx_bad_frame <= 1'b1;
            end
        end
    end

    // Every forwarded byte targets exactly one responder
    a_one_sel: assert property (@(posedge sys_clk) disable iff (rst)
        pay.valid |-> (pay.udp_sel ^ pay.icmp_sel));

endmodule

// File: logic/ip_tx_framer.sv
`timescale 1ns/100ps
`include "echo_settings.svh"

module ip_tx_framer (
    input  logic       sys_clk,
    input  logic       rst,
    reply_if.sink      tx_reply,
    output logic [7:0] tx_data,
    output logic       tx_valid,
    input  logic       tx_ready,
    output logic       tx_last
);

    localparam logic [31:0] SRC_IP = `LOCAL_IP;

    echo_pkg::tx_state_t state;
    logic [4:0]   cnt;
    logic [4:0]   l4_len;
    logic [15:0]  total_len;
    logic [19:0]  csum_acc;
    logic [16:0]  csum_fold;
    logic [15:0]  ip_csum;
    logic [159:0] ip_hdr;
    logic [63:0]  l4_hdr;
    logic         beat;

    // Header words with the checksum field as zero
    always_comb begin
        l4_len    = (tx_reply.meta.proto == echo_pkg::PROTO_UDP) ? 5'd8 : 5'd4;
        total_len = 16'd20 + 16'(l4_len) + 16'(tx_reply.meta.pay_len);
        csum_acc  = 20'h04500 + 20'(total_len) + 20'({`REPLY_TTL, tx_reply.meta.proto})
                  + 20'(SRC_IP[31:16]) + 20'(SRC_IP[15:0])
                  + 20'(tx_reply.meta.dst_ip[31:16]) + 20'(tx_reply.meta.dst_ip[15:0]);
        csum_fold = {1'b0, csum_acc[15:0]} + 17'(csum_acc[19:16]);
        ip_csum   = ~(csum_fold[15:0] + 16'(csum_fold[16]));
        ip_hdr    = {8'h45, 8'h00, total_len, 32'h0000_0000, `REPLY_TTL,
                     tx_reply.meta.proto, ip_csum, SRC_IP, tx_reply.meta.dst_ip};
        l4_hdr    = {tx_reply.meta.l4_word_a, tx_reply.meta.udp_len, 16'h0000};
    end

    always_comb begin
        case (state)
            echo_pkg::TX_IP_HDR: tx_data = ip_hdr[159 - 8*cnt -: 8];
            echo_pkg::TX_L4_HDR: tx_data = l4_hdr[63 - 8*cnt -: 8];
            default:             tx_data = tx_reply.data;
        endcase
    end

    assign tx_valid       = (state == echo_pkg::TX_IP_HDR) || (state == echo_pkg::TX_L4_HDR) ||
                            (state == echo_pkg::TX_PAYLOAD && tx_reply.valid);
    assign tx_last        = (state == echo_pkg::TX_PAYLOAD) && tx_reply.last;
    assign tx_reply.ready = (state == echo_pkg::TX_PAYLOAD) && tx_ready;
    assign beat           = tx_valid && tx_ready;

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            state <= echo_pkg::TX_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                echo_pkg::TX_IDLE: begin
                    if (tx_reply.req) begin
                        state <= echo_pkg::TX_IP_HDR;
                    end
                end
                echo_pkg::TX_IP_HDR: begin
                    if (beat) begin
                        cnt <= (cnt == 5'd19) ? '0 : cnt + 5'd1;
                        if (cnt == 5'd19) begin
                            state <= echo_pkg::TX_L4_HDR;
                        end
                    end
                end
                echo_pkg::TX_L4_HDR: begin
                    if (beat) begin
                        cnt <= (cnt == l4_len - 5'd1) ? '0 : cnt + 5'd1;
                        if (cnt == l4_len - 5'd1) begin
                            state <= echo_pkg::TX_PAYLOAD;
                        end
                    end
                end
                default: begin
                    if (beat && tx_reply.last) begin
                        state <= echo_pkg::TX_IDLE;
                    end
                end
            endcase
        end
    end

    // Holds across header and payload bytes alike
    a_tx_hold: assert property (@(posedge sys_clk) disable iff (rst)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_data) && $stable(tx_last));

endmodule

// File: logic/reply_arbiter.sv
`timescale 1ns/100ps

module reply_arbiter (
    input logic   sys_clk,
    input logic   rst,
    reply_if.sink udp_reply,
    reply_if.sink icmp_reply,
    reply_if.source tx_reply
);

    logic gnt_udp;
    logic gnt_icmp;
    logic prio_icmp;

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            gnt_udp   <= 1'b0;
            gnt_icmp  <= 1'b0;
            prio_icmp <= 1'b0;
        end else if (!gnt_udp && !gnt_icmp) begin
            if (udp_reply.req && (!icmp_reply.req || !prio_icmp)) begin
                gnt_udp <= 1'b1;
            end else if (icmp_reply.req) begin
                gnt_icmp <= 1'b1;
            end
        end else if (tx_reply.valid && tx_reply.ready && tx_reply.last) begin
            // Other side wins the next tie
            gnt_udp   <= 1'b0;
            gnt_icmp  <= 1'b0;
            prio_icmp <= gnt_udp;
        end
    end

    assign tx_reply.req     = (gnt_udp && udp_reply.req) || (gnt_icmp && icmp_reply.req);
    assign tx_reply.meta    = gnt_icmp ? icmp_reply.meta : udp_reply.meta;
    assign tx_reply.data    = gnt_icmp ? icmp_reply.data : udp_reply.data;
    assign tx_reply.valid   = (gnt_udp && udp_reply.valid) || (gnt_icmp && icmp_reply.valid);
    assign tx_reply.last    = gnt_icmp ? icmp_reply.last : udp_reply.last;
    assign udp_reply.ready  = gnt_udp && tx_reply.ready;
    assign icmp_reply.ready = gnt_icmp && tx_reply.ready;

    // One grant at most and only towards a live request
    a_one_grant: assert property (@(posedge sys_clk) disable iff (rst)
        !(gnt_udp && gnt_icmp) &&
        (!gnt_udp || udp_reply.req) &&
        (!gnt_icmp || icmp_reply.req));

endmodule

// File: logic/udp_echo.sv
`timescale 1ns/100ps
`include "echo_settings.svh"

module udp_echo (
    input logic         sys_clk,
    input logic         rst,
    rx_pay_if.responder pay,
    reply_if.source     reply
);

    localparam int LEN_W = $clog2(`ECHO_MAX_PAYLOAD) + 1;

    logic [7:0]       pay_mem [`ECHO_MAX_PAYLOAD];
    logic [LEN_W-1:0] wr_cnt;
    logic [LEN_W-1:0] rd_cnt;
    logic             drop;
    logic             sel_byte;
    logic             wr_ok;

    assign sel_byte = pay.valid && pay.udp_sel;
    // No writes while a reply is pending or once the buffer is full
    assign wr_ok    = sel_byte && !reply.req && !drop &&
                      (wr_cnt != LEN_W'(`ECHO_MAX_PAYLOAD));

    always_ff @(posedge sys_clk) begin
        if (wr_ok) begin
            pay_mem[wr_cnt[LEN_W-2:0]] <= pay.data + 8'd1;
        end
        if (wr_ok && pay.last) begin
            reply.meta <= '{proto:     echo_pkg::PROTO_UDP,
                            dst_ip:    pay.src_ip,
                            l4_word_a: {`UDP_ECHO_PORT, pay.src_port},
                            udp_len:   16'(wr_cnt) + 16'd9,
                            pay_len:   wr_cnt + 1'b1};
        end
    end

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            wr_cnt    <= '0;
            rd_cnt    <= '0;
            drop      <= 1'b0;
            reply.req <= 1'b0;
        end else begin
            if (sel_byte) begin
                wr_cnt <= pay.last ? '0 : wr_cnt + LEN_W'(wr_ok);
                drop   <= !pay.last && !wr_ok;
            end
            if (wr_ok && pay.last && !pay.err) begin
                reply.req <= 1'b1;
            end
            if (reply.valid && reply.ready) begin
                rd_cnt <= reply.last ? '0 : rd_cnt + 1'b1;
                if (reply.last) begin
                    reply.req <= 1'b0;
                end
            end
        end
    end

    assign reply.valid = reply.req;
    assign reply.data  = pay_mem[rd_cnt[LEN_W-2:0]];
    assign reply.last  = (rd_cnt + 1'b1 == LEN_W'(reply.meta.pay_len));

    a_meta_stable: assert property (@(posedge sys_clk) disable iff (rst)
        reply.req && !(reply.ready && reply.last) |=> $stable(reply.meta));

endmodule

// File: sim/echo_core_tb.sv
`timescale 1ns/100ps
`include "echo_settings.svh"

module echo_core_tb;

    localparam int NUM_PKTS       = 50;
    localparam int TIMEOUT_CYCLES = NUM_PKTS * 400;

    logic       sys_clk;
    logic       rst;
    logic [7:0] rx_data;
    logic       rx_valid;
    logic       rx_last;
    logic       rx_err;
    logic [7:0] tx_data;
    logic       tx_valid;
    logic       tx_ready = 1'b0;
    logic       tx_last;
    logic       rx_activity;
    logic       rx_bad_frame;

    bit           bp_on = 1'b0;
    int           cycles;
    int           errors;
    int           checks;
    int           passed;
    int           failed;
    int           cur_len;
    logic [7:0]   pkt [$];
    logic [7:0]   cap_data [$];
    int           cap_len [$];
    // Expected reply per responder with UDP at index 0 and ICMP at 1
    logic [159:0] exp_hdr [2];
    logic [63:0]  exp_l4 [2];
    logic [7:0]   exp_pay [2][128];
    int           exp_len [2];

    echo_core u_echo_core (
        .sys_clk      (sys_clk),
        .rst          (rst),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .rx_last      (rx_last),
        .rx_err       (rx_err),
        .tx_data      (tx_data),
        .tx_valid     (tx_valid),
        .tx_ready     (tx_ready),
        .tx_last      (tx_last),
        .rx_activity  (rx_activity),
        .rx_bad_frame (rx_bad_frame)
    );

    initial begin
        sys_clk = 1'b0;
        forever #5 sys_clk = ~sys_clk;
    end

    always @(posedge sys_clk) begin
        tx_ready <= bp_on ? 1'($urandom_range(0, 1)) : 1'b1;
    end

    // Collect every transmitted byte and one length entry per packet
    always @(posedge sys_clk) begin
        if (!rst && tx_valid && tx_ready) begin
            cap_data.push_back(tx_data);
            cur_len = cur_len + 1;
            if (tx_last) begin
                cap_len.push_back(cur_len);
                cur_len = 0;
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge sys_clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    task automatic compare(input string name, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
        checks++;
        if (exp_v !== act_v) begin
            errors++;
            $display("ERR %s expected %h actual %h", name, exp_v, act_v);
        end
    endtask

    function automatic logic [15:0] ip_csum(input logic [159:0] h);
        logic [31:0] sum;
        sum = 32'h0;
        for (int i = 0; i < 10; i++) begin
            sum = sum + {16'h0, h[159 - 16*i -: 16]};
        end
        while (sum[31:16] != 16'h0) begin
            sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
        end
        return ~sum[15:0];
    endfunction

    // Type byte drops by 8 from echo request to reply
    function automatic logic [15:0] icmp_adjust(input logic [15:0] c);
        logic [16:0] s;
        s = {1'b0, c} + 17'h00800;
        return s[16] ? s[15:0] + 16'd1 : s[15:0];
    endfunction

    function automatic int rand_len();
        return 1 + int'($urandom % 64);
    endfunction

    task automatic build_packet(input logic [7:0] proto, input logic [31:0] dst_ip,
                                input logic [15:0] dst_port, input logic [7:0] icmp_type,
                                input int len);
        logic [31:0]  src_ip;
        logic [15:0]  src_port;
        logic [15:0]  req_csum;
        logic [15:0]  total;
        logic [159:0] hdr;
        logic [63:0]  l4;
        int           l4n;
        int           idx;
        src_ip   = $urandom;
        src_port = 16'($urandom);
        req_csum = 16'($urandom);
        idx      = (proto == echo_pkg::PROTO_ICMP) ? 1 : 0;
        l4n      = (idx == 1) ? 4 : 8;
        total    = 16'(20 + l4n + len);
        l4       = (idx == 1) ? {icmp_type, 8'h00, req_csum, 32'h0}
                              : {src_port, dst_port, 16'(len + 8), 16'h0};
        hdr      = {8'h45, 8'h00, total, 16'h0000, 16'h4000, 8'd64, proto, 16'h0000,
                    src_ip, dst_ip};
        hdr[79:64] = ip_csum(hdr);
        pkt.delete();
        for (int i = 0; i < 20; i++) begin
            pkt.push_back(hdr[159 - 8*i -: 8]);
        end
        for (int i = 0; i < l4n; i++) begin
            pkt.push_back(l4[63 - 8*i -: 8]);
        end
        exp_len[idx] = len;
        for (int i = 0; i < len; i++) begin
            exp_pay[idx][i] = 8'($urandom);
            pkt.push_back(exp_pay[idx][i]);
        end
        // Reply goes back to the sender with the L4 fields rewritten
        hdr = {8'h45, 8'h00, total, 32'h0, `REPLY_TTL, proto, 16'h0000, `LOCAL_IP, src_ip};
        hdr[79:64]   = ip_csum(hdr);
        exp_hdr[idx] = hdr;
        exp_l4[idx]  = (idx == 1) ? {8'h00, 8'h00, icmp_adjust(req_csum), 32'h0}
                                  : {`UDP_ECHO_PORT, src_port, 16'(len + 8), 16'h0};
    endtask

    task automatic send_packet(input bit err, input bit more);
        for (int i = 0; i < pkt.size(); i++) begin
            @(posedge sys_clk);
            rx_data  <= pkt[i];
            rx_valid <= 1'b1;
            rx_last  <= (i == pkt.size() - 1);
            rx_err   <= err && (i == pkt.size() - 1);
        end
        if (!more) begin
            @(posedge sys_clk);
            rx_valid <= 1'b0;
            rx_last  <= 1'b0;
            rx_err   <= 1'b0;
        end
    endtask

    task automatic wait_replies(input int n);
        while (cap_len.size() < n) begin
            @(posedge sys_clk);
        end
    endtask

    // want < 0 takes the responder from the protocol byte of the reply
    task automatic check_reply(input string name, input int want, output int idx);
        int         n;
        int         l4n;
        int         exp_n;
        logic [7:0] b;
        logic [7:0] e;
        n     = cap_len.pop_front();
        idx   = (want >= 0) ? want : ((cap_data[9] == 8'd1) ? 1 : 0);
        l4n   = (idx == 1) ? 4 : 8;
        exp_n = 20 + l4n + exp_len[idx];
        compare({name, " length"}, 32'(exp_n), 32'(n));
        for (int i = 0; i < n; i++) begin
            b = cap_data.pop_front();
            if (i < 20) begin
                e = exp_hdr[idx][159 - 8*i -: 8];
            end else if (i < 20 + l4n) begin
                e = exp_l4[idx][63 - 8*(i - 20) -: 8];
            end else begin
                e = exp_pay[idx][(i - 20 - l4n) % 128] + ((idx == 0) ? 8'd1 : 8'd0);
            end
            if (i < exp_n) begin
                compare($sformatf("%s byte %0d", name, i), {24'h0, e}, {24'h0, b});
            end
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        if (errors == err_before) begin
            passed++;
            $display("test %s: ok", name);
        end else begin
            failed++;
            $display("test %s: failed with %0d errors", name, errors - err_before);
        end
    endtask

    initial begin
        int idx_a;
        int idx_b;
        int err0;
        void'($urandom(26));
        rst      <= 1'b1;
        rx_data  <= 8'h00;
        rx_valid <= 1'b0;
        rx_last  <= 1'b0;
        rx_err   <= 1'b0;
        repeat (5) @(posedge sys_clk);
        rst <= 1'b0;
        @(posedge sys_clk);

        err0 = errors;
        compare("udp_echo rx_activity after reset", 32'd0, {31'd0, rx_activity});
        compare("udp_echo tx_valid after reset", 32'd0, {31'd0, tx_valid});
        for (int k = 0; k < 20; k++) begin
            build_packet(echo_pkg::PROTO_UDP, `LOCAL_IP, `UDP_ECHO_PORT, 8'h00, rand_len());
            send_packet(1'b0, 1'b0);
            wait_replies(1);
            check_reply($sformatf("udp_echo pkt %0d", k), 0, idx_a);
        end
        finish_test("udp_echo", err0);

        err0 = errors;
        for (int k = 0; k < 20; k++) begin
            build_packet(echo_pkg::PROTO_ICMP, `LOCAL_IP, 16'h0,
                         echo_pkg::ICMP_ECHO_REQUEST, rand_len());
            send_packet(1'b0, 1'b0);
            wait_replies(1);
            check_reply($sformatf("icmp_echo pkt %0d", k), 1, idx_a);
        end
        finish_test("icmp_echo", err0);

        err0 = errors;
        compare("filtering bad_frame before", 32'd0, {31'd0, rx_bad_frame});
        build_packet(echo_pkg::PROTO_UDP, `LOCAL_IP, `UDP_ECHO_PORT + 16'd1, 8'h00, 10);
        send_packet(1'b0, 1'b0);
        build_packet(echo_pkg::PROTO_UDP, `LOCAL_IP ^ 32'h1, `UDP_ECHO_PORT, 8'h00, 10);
        send_packet(1'b0, 1'b0);
        build_packet(8'd6, `LOCAL_IP, `UDP_ECHO_PORT, 8'h00, 10);
        send_packet(1'b0, 1'b0);
        build_packet(echo_pkg::PROTO_ICMP, `LOCAL_IP, 16'h0, 8'd13, 10);
        send_packet(1'b0, 1'b0);
        build_packet(echo_pkg::PROTO_UDP, `LOCAL_IP, `UDP_ECHO_PORT, 8'h00, 10);
        send_packet(1'b1, 1'b0);
        repeat (400) @(posedge sys_clk);
        compare("filtering replies", 32'd0, 32'(cap_len.size()));
        compare("filtering rx_activity", 32'd1, {31'd0, rx_activity});
        compare("filtering rx_bad_frame", 32'd1, {31'd0, rx_bad_frame});
        finish_test("filtering", err0);

        err0 = errors;
        build_packet(echo_pkg::PROTO_UDP, `LOCAL_IP, `UDP_ECHO_PORT, 8'h00, 65);
        send_packet(1'b0, 1'b0);
        build_packet(echo_pkg::PROTO_ICMP, `LOCAL_IP, 16'h0, echo_pkg::ICMP_ECHO_REQUEST, 65);
        send_packet(1'b0, 1'b0);
        repeat (400) @(posedge sys_clk);
        compare("oversize replies", 32'd0, 32'(cap_len.size()));
        build_packet(echo_pkg::PROTO_UDP, `LOCAL_IP, `UDP_ECHO_PORT, 8'h00, rand_len());
        send_packet(1'b0, 1'b0);
        wait_replies(1);
        check_reply("oversize follow-up", 0, idx_a);
        finish_test("oversize", err0);

        // Both responders loaded back to back under random tx_ready
        err0 = errors;
        bp_on <= 1'b1;
        build_packet(echo_pkg::PROTO_UDP, `LOCAL_IP, `UDP_ECHO_PORT, 8'h00, rand_len());
        send_packet(1'b0, 1'b1);
        build_packet(echo_pkg::PROTO_ICMP, `LOCAL_IP, 16'h0,
                     echo_pkg::ICMP_ECHO_REQUEST, rand_len());
        send_packet(1'b0, 1'b0);
        wait_replies(2);
        check_reply("concurrency first", -1, idx_a);
        check_reply("concurrency second", -1, idx_b);
        compare("concurrency protocols", 32'd1, 32'(idx_a + idx_b));
        bp_on <= 1'b0;
        repeat (20) @(posedge sys_clk);
        compare("concurrency leftover", 32'd0, 32'(cap_len.size()));
        finish_test("concurrency", err0);

        $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
                 passed, failed, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
